/* Makefile */
# Verilator build and run of the instruction cache testbench

sim:
	verilator --binary --timing --assert --top-module tb_icache -f flist.f
	./obj_dir/Vtb_icache | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* flist.f */
src/icache_pkg.sv
src/icache_ctrl_fsm.sv
src/refill_counters.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_top.sv
testbench/tb_icache.sv

/* src/icache_ctrl_fsm.sv */
`timescale 1ns/1ps

module icache_ctrl_fsm (
    input  logic Clk,
    input  logic arst_n,
    input  logic req_valid,
    input  logic hit,
    input  logic credit_avail,
    input  logic last_beat,
    output logic lookup_en,
    output logic req_fire,
    output logic fill_commit,
    output logic rsp_valid,
    output logic rsp_from_fill,
    output logic busy
);
    import icache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt     = state;
        lookup_en     = 1'b0;
        req_fire      = 1'b0;
        fill_commit   = 1'b0;
        rsp_valid     = 1'b0;
        rsp_from_fill = 1'b0;

        case (state)
            IDLE: begin
                if (req_valid) begin      // Address already registered
                    lookup_en = 1'b1;
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    rsp_valid = 1'b1;
                    state_nxt = IDLE;
                end else begin
                    state_nxt = REQ;
                end
            end
            REQ: begin
                // Hold here until memory has room for the request
                if (credit_avail) begin
                    req_fire  = 1'b1;
                    state_nxt = FILL;
                end
            end
            FILL: begin
                if (last_beat) begin
                    fill_commit   = 1'b1;
                    rsp_valid     = 1'b1;
                    rsp_from_fill = 1'b1;  // Word comes from refill buffer
                    state_nxt     = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Pending request counts as busy before the lookup starts
    assign busy = (state != IDLE) || req_valid;

endmodule

/* src/icache_data_array.sv */
`timescale 1ns/1ps

module icache_data_array #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                           Clk,
    input  logic                           arst_n,
    input  logic [icache_pkg::ADDR_W-1:0]  addr,
    input  logic [$clog2(NUM_WAYS)-1:0]    hit_way,
    input  logic [$clog2(NUM_WAYS)-1:0]    fill_way,
    input  logic                           rsp_valid,
    input  logic                           rsp_from_fill,
    input  logic                           fill_commit,
    input  icache_pkg::mem_beat_t          mem_beat,
    input  logic [$clog2(BLOCK_WORDS)-1:0] beat_idx,
    output logic [icache_pkg::WORD_W-1:0]  instr
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(BLOCK_WORDS);
    localparam int SET_W = $clog2(NUM_SETS);
    localparam int OFF_W = 2 + IDX_W;

    logic [WORD_W-1:0] blocks    [NUM_SETS][NUM_WAYS][BLOCK_WORDS];
    logic [WORD_W-1:0] fill_buf  [BLOCK_WORDS];
    logic [WORD_W-1:0] fill_word [BLOCK_WORDS];

    logic [SET_W-1:0] set_idx;
    logic [IDX_W-1:0] word_off;

    assign set_idx  = addr[OFF_W +: SET_W];
    assign word_off = addr[2 +: IDX_W];

    // Buffer view with the beat of this cycle forwarded in
    always_comb begin
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            fill_word[i] = (mem_beat.valid && (beat_idx == IDX_W'(i))) ?
                           mem_beat.data : fill_buf[i];
        end
    end

    always_ff @(posedge Clk) begin
        if (mem_beat.valid) fill_buf[beat_idx] <= mem_beat.data;
        if (fill_commit) begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                blocks[set_idx][fill_way][i] <= fill_word[i];
            end
        end
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            instr <= '0;
        end else if (rsp_valid) begin
            instr <= rsp_from_fill ? fill_word[word_off] : blocks[set_idx][hit_way][word_off];
        end
    end

endmodule

/* src/icache_pkg.sv */
package icache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // Default geometry, overridden from the top level
    localparam int DEF_NUM_SETS    = 8;
    localparam int DEF_NUM_WAYS    = 4;
    localparam int DEF_BLOCK_WORDS = 4;

    localparam int MEM_CREDITS_MAX = 4;   // Upper bound of credit counter

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] instr;
    } fetch_rsp_t;

    // Block-aligned read request towards memory
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } mem_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REQ,
        FILL
    } ctrl_state_t;

endpackage

/* src/icache_tag_array.sv */
`timescale 1ns/1ps

module icache_tag_array #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                          Clk,
    input  logic                          arst_n,
    input  logic                          lookup_en,
    input  logic [icache_pkg::ADDR_W-1:0] addr,
    input  logic                          fill_commit,
    output logic                          hit,
    output logic [$clog2(NUM_WAYS)-1:0]   hit_way,
    output logic [$clog2(NUM_WAYS)-1:0]   fill_way
);
    import icache_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int SET_W = $clog2(NUM_SETS);
    localparam int OFF_W = 2 + $clog2(BLOCK_WORDS);
    localparam int TAG_W = ADDR_W - SET_W - OFF_W;

    logic [TAG_W-1:0]    tags   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid  [NUM_SETS];
    logic [WAY_W-1:0]    rr_ptr [NUM_SETS];

    logic [SET_W-1:0] set_idx;
    logic [TAG_W-1:0] tag;
    logic             hit_c;
    logic [WAY_W-1:0] hit_way_c;
    logic             any_invalid;
    logic [WAY_W-1:0] victim_c;
    logic             victim_rr;   // Victim was taken from the pointer

    assign set_idx = addr[OFF_W +: SET_W];
    assign tag     = addr[ADDR_W-1 -: TAG_W];

    always_comb begin
        hit_c       = 1'b0;
        hit_way_c   = '0;
        any_invalid = 1'b0;
        victim_c    = rr_ptr[set_idx];
        // Downward scan leaves the lowest invalid way
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (valid[set_idx][w] && (tags[set_idx][w] == tag)) begin
                hit_c     = 1'b1;
                hit_way_c = WAY_W'(w);
            end
            if (!valid[set_idx][w]) begin
                any_invalid = 1'b1;
                victim_c    = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hit       <= 1'b0;
            victim_rr <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else begin
            if (lookup_en) begin
                hit <= hit_c;
                if (!hit_c) victim_rr <= !any_invalid;
            end
            if (fill_commit) begin
                valid[set_idx][fill_way] <= 1'b1;
                if (victim_rr) begin
                    rr_ptr[set_idx] <= (rr_ptr[set_idx] == WAY_W'(NUM_WAYS - 1)) ?
                                       '0 : rr_ptr[set_idx] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (lookup_en) begin
            hit_way <= hit_way_c;
            if (!hit_c) fill_way <= victim_c;
        end
        if (fill_commit) tags[set_idx][fill_way] <= tag;
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int NUM_SETS    = icache_pkg::DEF_NUM_SETS,
    parameter int NUM_WAYS    = icache_pkg::DEF_NUM_WAYS,
    parameter int BLOCK_WORDS = icache_pkg::DEF_BLOCK_WORDS
) (
    input  logic                   Clk,
    input  logic                   arst_n,
    input  icache_pkg::fetch_req_t fetch_req,
    input  logic                   mem_credit,
    input  icache_pkg::mem_beat_t  mem_beat,
    output icache_pkg::fetch_rsp_t fetch_rsp,
    output logic                   busy,
    output icache_pkg::mem_req_t   mem_req
);
    import icache_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int IDX_W = $clog2(BLOCK_WORDS);
    localparam int OFF_W = 2 + IDX_W;

    logic [ADDR_W-1:0] addr_q;
    logic              req_q;
    logic              rsp_q;
    logic              accept;

    logic              lookup_en, req_fire, fill_commit, rsp_valid, rsp_from_fill;
    logic              hit, credit_avail, last_beat;
    logic [WAY_W-1:0]  hit_way, fill_way;
    logic [IDX_W-1:0]  beat_idx;
    logic [WORD_W-1:0] instr;

    assign accept = fetch_req.valid && !busy;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= 1'b0;
            rsp_q <= 1'b0;
        end else begin
            req_q <= accept;      // Starts the lookup next cycle
            rsp_q <= rsp_valid;
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) addr_q <= fetch_req.addr;
    end

    icache_ctrl_fsm u_icache_ctrl_fsm (
        .Clk, .arst_n, .req_valid(req_q), .hit, .credit_avail, .last_beat,
        .lookup_en, .req_fire, .fill_commit, .rsp_valid, .rsp_from_fill, .busy
    );

    refill_counters #(.BLOCK_WORDS(BLOCK_WORDS)) u_refill_counters (
        .Clk, .arst_n, .mem_credit, .req_fire, .beat_valid(mem_beat.valid),
        .credit_avail, .beat_idx, .last_beat
    );

    icache_tag_array #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS), .BLOCK_WORDS(BLOCK_WORDS))
        u_icache_tag_array (
        .Clk, .arst_n, .lookup_en, .addr(addr_q), .fill_commit, .hit, .hit_way, .fill_way
    );

    icache_data_array #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS), .BLOCK_WORDS(BLOCK_WORDS))
        u_icache_data_array (
        .Clk, .arst_n, .addr(addr_q), .hit_way, .fill_way, .rsp_valid, .rsp_from_fill,
        .fill_commit, .mem_beat, .beat_idx, .instr
    );

    // Whole block is fetched, so low offset bits are zero
    assign mem_req.valid   = req_fire;
    assign mem_req.addr    = {addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign fetch_rsp.valid = rsp_q;
    assign fetch_rsp.instr = instr;

endmodule

/* src/refill_counters.sv */
`timescale 1ns/1ps

module refill_counters #(
    parameter int BLOCK_WORDS = 4
) (
    input  logic                           Clk,
    input  logic                           arst_n,
    input  logic                           mem_credit,
    input  logic                           req_fire,
    input  logic                           beat_valid,
    output logic                           credit_avail,
    output logic [$clog2(BLOCK_WORDS)-1:0] beat_idx,
    output logic                           last_beat
);
    import icache_pkg::*;

    localparam int CRED_W = $clog2(MEM_CREDITS_MAX + 1);
    localparam int IDX_W  = $clog2(BLOCK_WORDS);

    logic [CRED_W-1:0] credits;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            credits  <= '0;
            beat_idx <= '0;
        end else begin
            case ({mem_credit, req_fire})
                2'b10: if (credits != CRED_W'(MEM_CREDITS_MAX)) credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: ;   // Return and spend cancel out
            endcase

            if (req_fire) begin
                beat_idx <= '0;
            end else if (beat_valid) begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    assign credit_avail = (credits != '0);
    assign last_beat    = beat_valid && (beat_idx == IDX_W'(BLOCK_WORDS - 1));

endmodule

/* testbench/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int NUM_SETS    = DEF_NUM_SETS;
    localparam int NUM_WAYS    = DEF_NUM_WAYS;
    localparam int BLOCK_WORDS = DEF_BLOCK_WORDS;
    localparam int OFF_W       = 2 + $clog2(BLOCK_WORDS);
    localparam int SET_W       = $clog2(NUM_SETS);
    localparam int N_RANDOM    = 300;
    localparam int N_REQS      = 5 + 2 + 10 + 1 + N_RANDOM;
    localparam int MAX_CYCLES  = N_REQS * (BLOCK_WORDS * 2 + 10) + 200;
    localparam logic [31:0] DATA_KEY   = 32'h5A5A_0F0F;
    localparam logic [31:0] BLOCK_MASK = ~(32'(BLOCK_WORDS * 4) - 32'd1);
    localparam int TAG_SEQ [10] = '{1, 2, 3, 4, 5, 6, 6, 5, 4, 3};  // Six tags, then revisits

    logic       Clk = 1'b0;
    logic       arst_n = 1'b0;
    fetch_req_t fetch_req = '0;
    logic       mem_credit = 1'b0;
    mem_beat_t  mem_beat = '0;
    fetch_rsp_t fetch_rsp;
    logic       busy;
    mem_req_t   mem_req;

    integer seed = 16048;
    int cycles = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    int          init_credits = 0;
    int          credit_grants = 0;   // Extra credits granted by a test
    int          grants_seen = 0;
    int          pending_credits = 0;
    int          ret_timer = 0;
    int          beats_left = 0;
    logic        gap_taken = 1'b0;
    logic [31:0] beat_addr = '0;
    int          req_count = 0;
    logic [31:0] last_req_addr = '0;

    logic [31:0]         ref_tag   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] ref_valid [NUM_SETS];
    int                  ref_rr    [NUM_SETS];

    icache_top #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS), .BLOCK_WORDS(BLOCK_WORDS)) u_icache_top (
        .Clk, .arst_n, .fetch_req, .mem_credit, .mem_beat, .fetch_rsp, .busy, .mem_req
    );

    always #10 Clk = ~Clk;

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the cache stopped making progress", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // Memory side: credits, block beats, request log
    always @(posedge Clk) begin
        mem_credit <= 1'b0;
        mem_beat   <= '0;
        if (!arst_n) begin
            pending_credits = init_credits;
            ret_timer       = 0;
            beats_left      = 0;
            gap_taken       = 1'b0;
        end else begin
            if (credit_grants != grants_seen) begin
                pending_credits = pending_credits + 1;
                grants_seen     = grants_seen + 1;
            end
            if (ret_timer > 0) begin
                ret_timer = ret_timer - 1;
                if (ret_timer == 0) pending_credits = pending_credits + 1;
            end
            if (pending_credits > 0) begin
                mem_credit     <= 1'b1;
                pending_credits = pending_credits - 1;
            end
            if (beats_left > 0) begin
                if (!gap_taken && (($random(seed) & 1) != 0)) begin
                    gap_taken = 1'b1;   // Never two idle cycles in a row
                end else begin
                    mem_beat  <= {1'b1, beat_addr ^ DATA_KEY};
                    beat_addr  = beat_addr + 32'd4;
                    beats_left = beats_left - 1;
                    gap_taken  = 1'b0;
                end
            end
            if (mem_req.valid) begin
                req_count     = req_count + 1;
                last_req_addr = mem_req.addr;
                beat_addr     = mem_req.addr;
                beats_left    = BLOCK_WORDS;
                ret_timer     = 2;
            end
        end
    end

    task automatic clear_model();
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[s] = '0;
            ref_rr[s]    = 0;
        end
    endtask

    // Lowest invalid way first, then the set's round-robin pointer
    task automatic model_access(input logic [31:0] addr, output logic hit);
        logic [SET_W-1:0] s;
        logic [31:0]      t;
        int               victim;
        s      = addr[OFF_W +: SET_W];
        t      = addr >> (OFF_W + SET_W);
        hit    = 1'b0;
        victim = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[s][w] && (ref_tag[s][w] == t)) hit = 1'b1;
            if (!ref_valid[s][w] && (victim < 0)) victim = w;
        end
        if (!hit) begin
            if (victim < 0) begin
                victim    = ref_rr[s];
                ref_rr[s] = (ref_rr[s] + 1) % NUM_WAYS;
            end
            ref_tag[s][victim]   = t;
            ref_valid[s][victim] = 1'b1;
        end
    endtask

    task automatic apply_reset(input int credits);
        init_credits = credits;
        @(posedge Clk);
        arst_n <= 1'b0;
        repeat (3) @(posedge Clk);
        arst_n <= 1'b1;
        clear_model();
    endtask

    task automatic send_req(input logic [31:0] addr);
        @(negedge Clk);
        while (busy) @(negedge Clk);
        @(posedge Clk);
        fetch_req <= {1'b1, addr};
        @(posedge Clk);   // Acceptance edge
        fetch_req <= '0;
    endtask

    // Latency counts clock edges from the acceptance edge
    task automatic wait_rsp(output logic [31:0] word, output int lat);
        lat = 0;
        @(negedge Clk);
        while (!fetch_rsp.valid) begin
            @(negedge Clk);
            lat++;
        end
        word = fetch_rsp.instr;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    task automatic access(input string name, input logic [31:0] addr, output logic hit);
        logic [31:0] word;
        int          lat;
        int          reqs_before;
        model_access(addr, hit);
        reqs_before = req_count;
        send_req(addr);
        wait_rsp(word, lat);
        check_value({name, " word"}, addr ^ DATA_KEY, word);
        check_value({name, " mem_req count"}, hit ? 32'd0 : 32'd1, 32'(req_count - reqs_before));
        if (hit) begin
            check_value({name, " hit latency"}, 32'd2, 32'(lat));
        end else begin
            check_value({name, " mem_req addr"}, addr & BLOCK_MASK, last_req_addr);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        logic        hit;
        logic [31:0] addr;
        logic [31:0] word;
        int          lat;
        int          mark;
        int          reqs_before;
        int          n_hit;
        int          n_miss;

        apply_reset(2);
        mark = errors;
        repeat (10) begin
            @(negedge Clk);
            check_true(!busy && !mem_req.valid && !fetch_rsp.valid, "output active while idle");
        end
        report_test("reset_idle", mark);

        mark = errors;
        access("cold_miss", 32'h0000_1048, hit);
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            access("block_offsets", 32'h0000_1040 + 32'(4 * i), hit);
        end
        report_test("cold_miss", mark);

        mark = errors;
        access("hit_fill", 32'h0000_2004, hit);
        access("hit_timing", 32'h0000_2004, hit);
        report_test("hit_timing", mark);

        mark = errors;
        for (int i = 0; i < 10; i++) begin
            addr = (32'(TAG_SEQ[i]) << (OFF_W + SET_W)) | (32'd5 << OFF_W);
            access("replacement", addr, hit);
        end
        report_test("replacement", mark);

        apply_reset(0);   // No credits at all
        mark = errors;
        addr = 32'h0000_3010;
        model_access(addr, hit);
        reqs_before = req_count;
        send_req(addr);
        repeat (20) begin
            @(negedge Clk);
            check_true(busy && !mem_req.valid, "memory request or idle without a credit");
        end
        check_value("backpressure mem_req count", 32'd0, 32'(req_count - reqs_before));
        credit_grants = credit_grants + 1;
        wait_rsp(word, lat);
        check_value("backpressure word", addr ^ DATA_KEY, word);
        check_value("backpressure mem_req count", 32'd1, 32'(req_count - reqs_before));
        check_value("backpressure mem_req addr", addr & BLOCK_MASK, last_req_addr);
        report_test("credit_backpressure", mark);

        mark   = errors;
        n_hit  = 0;
        n_miss = 0;
        for (int i = 0; i < N_RANDOM; i++) begin
            addr = 32'h0000_4000 + ($random(seed) & 32'h0000_03FC);  // 1 KB window
            access("random", addr, hit);
            if (hit) begin
                n_hit++;
            end else begin
                n_miss++;
            end
        end
        $display("Random run: %0d hits, %0d misses", n_hit, n_miss);
        report_test("random", mark);

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
